// File: hdl/cp15Pkg.sv
package cp15Pkg;

  // **************************************************
  // Register index width and fixed register numbers
  // **************************************************

  // CRn field from paddr[5:2]
  localparam int CRN_W = 4;

  // Read-only main ID register
  localparam logic [CRN_W-1:0] CRN_ID      = 4'd0;
  // Control register, always visible to the core
  localparam logic [CRN_W-1:0] CRN_CONTROL = 4'd1;
  // Translation table base, always visible to the MMU
  localparam logic [CRN_W-1:0] CRN_TBASE   = 4'd2;
  // Cache maintenance operations
  localparam logic [CRN_W-1:0] CRN_CACHE   = 4'd7;
  // TLB maintenance operations
  localparam logic [CRN_W-1:0] CRN_TLB     = 4'd8;

  // **************************************************
  // Decoded CPU operation
  // **************************************************

  typedef enum logic [2:0] {
    opNone,
    opRead,
    opWrite,
    opCacheMaint,
    opTlbMaint,
    opError
  } cp15Op_t;

  // **************************************************
  // Wait-state and priority tracker
  // **************************************************

  typedef enum logic [1:0] {
    rsIdle,
    // CPU lost at least one conflict
    rsWait,
    // CPU wins the next conflict
    rsPriority
  } resultState_t;

endpackage

// File: hdl/cp15Decode.sv
module cp15Decode (
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [12:0]                    paddr,
  input  logic                           mmuEn,
  input  logic                           mmuWriteEn,
  input  logic [cp15Pkg::CRN_W-1:0]      mmuAddr,
  input  logic                           cpuPriority,
  output cp15Pkg::cp15Op_t               cpuOp,
  output logic [cp15Pkg::CRN_W-1:0]      cpuReg,
  output logic [3:0]                     cacheMask,
  output logic [1:0]                     tlbMask,
  output logic                           cpuAccept,
  output logic                           mmuStall
);

  logic [3:0] crm;
  logic [2:0] opcode2;
  logic       opcode2Ok;
  logic       cacheHit;
  logic [3:0] cacheEntry;
  logic       tlbHit;
  logic [1:0] tlbEntry;
  logic       cpuAccess;
  logic       conflict;

  // APB address fields
  assign cpuReg  = paddr[5:2];
  assign crm     = paddr[9:6];
  assign opcode2 = paddr[12:10];

  // Only opcode2 0 and 1 select a maintenance operation
  assign opcode2Ok = (opcode2[2:1] == 2'b00);

  // Cache table, mask order is flushI flushD cleanI cleanD
  always_comb begin
    cacheHit   = opcode2Ok;
    cacheEntry = 4'b0000;
    case (crm)
      4'd7:    cacheEntry = 4'b1100;
      4'd5:    cacheEntry = 4'b1000;
      4'd6:    cacheEntry = 4'b0100;
      4'd11:   cacheEntry = 4'b0011;
      4'd10:   cacheEntry = 4'b0001;
      4'd15:   cacheEntry = 4'b1111;
      4'd14:   cacheEntry = 4'b0101;
      default: cacheHit   = 1'b0;
    endcase
  end

  // TLB table, mask order is tlbFlushI tlbFlushD
  always_comb begin
    tlbHit   = opcode2Ok;
    tlbEntry = 2'b00;
    case (crm)
      4'd7:    tlbEntry = 2'b11;
      4'd5:    tlbEntry = 2'b10;
      4'd6:    tlbEntry = 2'b01;
      default: tlbHit   = 1'b0;
    endcase
  end

  // **************************************************
  // CPU operation
  // **************************************************

  always_comb begin
    cpuOp     = cp15Pkg::opNone;
    cacheMask = 4'b0000;
    tlbMask   = 2'b00;
    if (psel) begin
      // Word aligned accesses only
      if (paddr[1:0] != 2'b00) begin
        cpuOp = cp15Pkg::opError;
      end else if (!pwrite) begin
        cpuOp = cp15Pkg::opRead;
      end else begin
        case (cpuReg)
          cp15Pkg::CRN_ID: cpuOp = cp15Pkg::opError;
          cp15Pkg::CRN_CACHE: begin
            cpuOp     = cacheHit ? cp15Pkg::opCacheMaint : cp15Pkg::opError;
            cacheMask = cacheHit ? cacheEntry : 4'b0000;
          end
          cp15Pkg::CRN_TLB: begin
            cpuOp   = tlbHit ? cp15Pkg::opTlbMaint : cp15Pkg::opError;
            tlbMask = tlbHit ? tlbEntry : 2'b00;
          end
          default: cpuOp = cp15Pkg::opWrite;
        endcase
      end
    end
  end

  // CPU loses a conflict unless the tracker granted it priority
  assign cpuAccess = psel && penable;
  assign conflict  = cpuAccess && mmuEn;
  assign cpuAccept = cpuAccess && (!mmuEn || cpuPriority);
  assign mmuStall  = conflict && cpuPriority;

  // The MMU should never try to write the ID register
  always_comb begin
    if (mmuEn && mmuWriteEn) begin
      assert (mmuAddr != cp15Pkg::CRN_ID)
        else $error("MMU write aimed at read-only CRn 0");
    end
  end

endmodule

// File: hdl/cp15RegFile.sv
module cp15RegFile #(
  parameter logic [31:0] resetId      = 32'h41069265,
  parameter logic [31:0] resetControl = 32'h00090078
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           writeEn,
  input  logic [cp15Pkg::CRN_W-1:0]      writeReg,
  input  logic [31:0]                    writeData,
  input  logic [cp15Pkg::CRN_W-1:0]      cpuReg,
  output logic [31:0]                    cpuReadData,
  input  logic [cp15Pkg::CRN_W-1:0]      mmuAddr,
  output logic [31:0]                    mmuReadData,
  output logic [31:0]                    control,
  output logic [31:0]                    tbase
);

  localparam int NumRegs = 1 << cp15Pkg::CRN_W;

  logic [31:0] regs [NumRegs];

  // **************************************************
  // Register storage
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      regs[cp15Pkg::CRN_ID]      <= resetId;
      regs[cp15Pkg::CRN_CONTROL] <= resetControl;
      for (int i = 2; i < NumRegs; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (writeEn && (writeReg != cp15Pkg::CRN_ID)) begin
      // CRn 0 keeps its reset value
      regs[writeReg] <= writeData;
    end
  end

  // Two independent combinational read ports
  assign cpuReadData = regs[cpuReg];
  assign mmuReadData = regs[mmuAddr];

  // Control and translation base are always visible
  assign control = regs[cp15Pkg::CRN_CONTROL];
  assign tbase   = regs[cp15Pkg::CRN_TBASE];

  // ID register holds its value whatever the CPU or MMU do
  idStable : assert property (
    @(posedge clk) disable iff (reset)
    $stable(regs[cp15Pkg::CRN_ID])
  ) else $error("CRn 0 changed after reset");

endmodule

// File: hdl/cp15Execute.sv
module cp15Execute #(
  parameter logic [31:0] resetId      = 32'h41069265,
  parameter logic [31:0] resetControl = 32'h00090078
) (
  input  logic                           clk,
  input  logic                           reset,
  input  cp15Pkg::cp15Op_t               cpuOp,
  input  logic [cp15Pkg::CRN_W-1:0]      cpuReg,
  input  logic [31:0]                    pwdata,
  input  logic [3:0]                     cacheMask,
  input  logic [1:0]                     tlbMask,
  input  logic                           cpuAccept,
  input  logic                           mmuEn,
  input  logic                           mmuWriteEn,
  input  logic [cp15Pkg::CRN_W-1:0]      mmuAddr,
  input  logic [31:0]                    mmuWriteData,
  input  logic                           mmuStall,
  output logic [31:0]                    cpuReadData,
  output logic [31:0]                    mmuReadData,
  output logic [31:0]                    control,
  output logic [31:0]                    tbase,
  output logic                           flushI,
  output logic                           flushD,
  output logic                           cleanI,
  output logic                           cleanD,
  output logic                           tlbFlushI,
  output logic                           tlbFlushD
);

  logic                      cpuWrite;
  logic                      mmuWrite;
  logic                      cacheFire;
  logic                      tlbFire;
  logic                      writeEn;
  logic [cp15Pkg::CRN_W-1:0] writeReg;
  logic [31:0]               writeData;

  // Maintenance writes also store their data
  assign cacheFire = cpuAccept && (cpuOp == cp15Pkg::opCacheMaint);
  assign tlbFire   = cpuAccept && (cpuOp == cp15Pkg::opTlbMaint);
  assign cpuWrite  = cacheFire || tlbFire || (cpuAccept && (cpuOp == cp15Pkg::opWrite));
  assign mmuWrite  = mmuEn && mmuWriteEn && !mmuStall;

  // Write port source select
  assign writeEn   = cpuWrite || mmuWrite;
  assign writeReg  = cpuWrite ? cpuReg : mmuAddr;
  assign writeData = cpuWrite ? pwdata : mmuWriteData;

  cp15RegFile #(
    .resetId      (resetId),
    .resetControl (resetControl)
  ) regFile (
    .clk         (clk),
    .reset       (reset),
    .writeEn     (writeEn),
    .writeReg    (writeReg),
    .writeData   (writeData),
    .cpuReg      (cpuReg),
    .cpuReadData (cpuReadData),
    .mmuAddr     (mmuAddr),
    .mmuReadData (mmuReadData),
    .control     (control),
    .tbase       (tbase)
  );

  // **************************************************
  // One-cycle maintenance pulses
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      {flushI, flushD, cleanI, cleanD} <= 4'b0000;
      {tlbFlushI, tlbFlushD}           <= 2'b00;
    end else begin
      {flushI, flushD, cleanI, cleanD} <= cacheFire ? cacheMask : 4'b0000;
      {tlbFlushI, tlbFlushD}           <= tlbFire ? tlbMask : 2'b00;
    end
  end

  // Arbitration in the decoder keeps the write port single-owner
  oneWriter : assert property (
    @(posedge clk) disable iff (reset)
    !(cpuWrite && mmuWrite)
  ) else $error("CPU and MMU wrote in the same cycle");

endmodule

// File: hdl/cp15Result.sv
module cp15Result #(
  parameter int stallLimit = 3
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   mmuEn,
  input  logic                   cpuAccept,
  input  cp15Pkg::cp15Op_t       cpuOp,
  input  logic [31:0]            cpuReadData,
  output logic                   pready,
  output logic                   pslverr,
  output logic [31:0]            prdata,
  output logic                   cpuPriority
);

  localparam int CountW = $clog2(stallLimit + 1);
  localparam logic [CountW-1:0] LastWait = CountW'(stallLimit - 1);

  cp15Pkg::resultState_t state;
  logic [CountW-1:0]     waitCount;
  logic                  waitCycle;
  logic                  lowCycle;
  logic [7:0]            lowRun;

  // **************************************************
  // APB response
  // **************************************************

  assign pready  = cpuAccept;
  assign pslverr = cpuAccept && (cpuOp == cp15Pkg::opError);
  assign prdata  = (cpuAccept && (cpuOp == cp15Pkg::opRead)) ? cpuReadData : 32'h0;

  // **************************************************
  // Wait-state and priority tracker
  // **************************************************

  // Access phase lost to the MMU
  assign waitCycle   = psel && penable && mmuEn && !cpuAccept;
  assign cpuPriority = (state == cp15Pkg::rsPriority);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= cp15Pkg::rsIdle;
      waitCount <= '0;
    end else begin
      case (state)
        cp15Pkg::rsIdle, cp15Pkg::rsWait: begin
          if (waitCycle) begin
            if (waitCount == LastWait) begin
              state     <= cp15Pkg::rsPriority;
              waitCount <= '0;
            end else begin
              state     <= cp15Pkg::rsWait;
              waitCount <= waitCount + CountW'(1);
            end
          end else begin
            // Transfer done or abandoned
            state     <= cp15Pkg::rsIdle;
            waitCount <= '0;
          end
        end
        cp15Pkg::rsPriority: begin
          if (cpuAccept || !psel) begin
            state <= cp15Pkg::rsIdle;
          end
        end
        default: state <= cp15Pkg::rsIdle;
      endcase
    end
  end

  // Run length of low pready during access, counted apart from the tracker
  assign lowCycle = psel && penable && !pready;

  always_ff @(posedge clk) begin
    if (reset || !lowCycle) begin
      lowRun <= 8'd0;
    end else begin
      lowRun <= lowRun + 8'd1;
    end
  end

  noStarve : assert property (
    @(posedge clk) disable iff (reset)
    !(lowCycle && (int'(lowRun) >= stallLimit + 1))
  ) else $error("pready low for more than stallLimit + 1 access cycles");

endmodule

// File: hdl/cp15Top.sv
module cp15Top #(
  parameter logic [31:0] resetId      = 32'h41069265,
  parameter logic [31:0] resetControl = 32'h00090078,
  parameter int          stallLimit   = 3
) (
  input  logic                           clk,
  input  logic                           reset,
  // APB from the core
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [12:0]                    paddr,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  // MMU port
  input  logic                           mmuEn,
  input  logic                           mmuWriteEn,
  input  logic [cp15Pkg::CRN_W-1:0]      mmuAddr,
  input  logic [31:0]                    mmuWriteData,
  output logic [31:0]                    mmuReadData,
  output logic                           mmuStall,
  output logic [31:0]                    control,
  output logic [31:0]                    tbase,
  output logic                           flushI,
  output logic                           flushD,
  output logic                           cleanI,
  output logic                           cleanD,
  output logic                           tlbFlushI,
  output logic                           tlbFlushD
);

  cp15Pkg::cp15Op_t          cpuOp;
  logic [cp15Pkg::CRN_W-1:0] cpuReg;
  logic [3:0]                cacheMask;
  logic [1:0]                tlbMask;
  logic                      cpuAccept;
  logic                      cpuPriority;
  logic [31:0]               cpuReadData;

  cp15Decode decode (
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .mmuEn       (mmuEn),
    .mmuWriteEn  (mmuWriteEn),
    .mmuAddr     (mmuAddr),
    .cpuPriority (cpuPriority),
    .cpuOp       (cpuOp),
    .cpuReg      (cpuReg),
    .cacheMask   (cacheMask),
    .tlbMask     (tlbMask),
    .cpuAccept   (cpuAccept),
    .mmuStall    (mmuStall)
  );

  cp15Execute #(
    .resetId      (resetId),
    .resetControl (resetControl)
  ) execute (
    .clk          (clk),
    .reset        (reset),
    .cpuOp        (cpuOp),
    .cpuReg       (cpuReg),
    .pwdata       (pwdata),
    .cacheMask    (cacheMask),
    .tlbMask      (tlbMask),
    .cpuAccept    (cpuAccept),
    .mmuEn        (mmuEn),
    .mmuWriteEn   (mmuWriteEn),
    .mmuAddr      (mmuAddr),
    .mmuWriteData (mmuWriteData),
    .mmuStall     (mmuStall),
    .cpuReadData  (cpuReadData),
    .mmuReadData  (mmuReadData),
    .control      (control),
    .tbase        (tbase),
    .flushI       (flushI),
    .flushD       (flushD),
    .cleanI       (cleanI),
    .cleanD       (cleanD),
    .tlbFlushI    (tlbFlushI),
    .tlbFlushD    (tlbFlushD)
  );

  cp15Result #(
    .stallLimit (stallLimit)
  ) result (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .mmuEn       (mmuEn),
    .cpuAccept   (cpuAccept),
    .cpuOp       (cpuOp),
    .cpuReadData (cpuReadData),
    .pready      (pready),
    .pslverr     (pslverr),
    .prdata      (prdata),
    .cpuPriority (cpuPriority)
  );

endmodule

// File: sim/cp15Tb.sv
module cp15Tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int StallLimit = 3;
  localparam int WaitLimit = 20;
  localparam logic [31:0] LfsrTaps = 32'h80200003;
  localparam logic [63:0] KindApbRead = 64'("apbRead");
  localparam logic [63:0] KindApbWrite = 64'("apbWrite");
  localparam logic [63:0] KindMmuRead = 64'("mmuRead");
  localparam logic [63:0] KindMmuWrite = 64'("mmuWrite");
  localparam logic [63:0] KindConflict = 64'("conflict");

  logic        clk = 1'b0;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [12:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        mmuEn;
  logic        mmuWriteEn;
  logic [3:0]  mmuAddr;
  logic [31:0] mmuWriteData;
  logic [31:0] mmuReadData;
  logic        mmuStall;
  logic [31:0] control;
  logic [31:0] tbase;
  logic        flushI;
  logic        flushD;
  logic        cleanI;
  logic        cleanD;
  logic        tlbFlushI;
  logic        tlbFlushD;

  logic [31:0] lfsrState = 32'h44b4121b;
  logic [31:0] lastRandom = 32'h0;
  // Expected control and tbase outputs
  logic [31:0] controlModel;
  logic [31:0] tbaseModel;
  int          testErrors = 0;
  int          errorCount = 0;
  int          testCount = 0;
  int          failedTests = 0;

  cp15Top i_dut (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .mmuEn        (mmuEn),
    .mmuWriteEn   (mmuWriteEn),
    .mmuAddr      (mmuAddr),
    .mmuWriteData (mmuWriteData),
    .mmuReadData  (mmuReadData),
    .mmuStall     (mmuStall),
    .control      (control),
    .tbase        (tbase),
    .flushI       (flushI),
    .flushD       (flushD),
    .cleanI       (cleanI),
    .cleanD       (cleanD),
    .tlbFlushI    (tlbFlushI),
    .tlbFlushD    (tlbFlushD)
  );

  always #4 clk = ~clk;

  // **************************************************
  // Random data and checks
  // **************************************************

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LfsrTaps;
    end
    return state >> 1;
  endfunction

  // One LFSR step per data bit taken
  task automatic drawRandom(output logic [31:0] word);
    word = 32'h0;
    for (int i = 0; i < 32; i++) begin
      word = {word[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected) else begin
      $display("ERROR %s got %h expected %h", name, got, expected);
      testErrors++;
    end
  endtask

  task automatic reportFailure(input string what);
    $display("%s", what);
    testErrors++;
  endtask

  task automatic checkOutputs(input logic [3:0] expCache, input logic [1:0] expTlb);
    checkValue("flushI/flushD/cleanI/cleanD", {28'h0, flushI, flushD, cleanI, cleanD},
               {28'h0, expCache});
    checkValue("tlbFlushI/tlbFlushD", {30'h0, tlbFlushI, tlbFlushD}, {30'h0, expTlb});
    checkValue("control", control, controlModel);
    checkValue("tbase", tbase, tbaseModel);
  endtask

  task automatic finishTest(input int lineNo);
    testCount++;
    if (testErrors == 0) begin
      $display("test %0d (line %0d) passed", testCount, lineNo);
    end else begin
      $display("test %0d (line %0d) failed with %0d errors", testCount, lineNo, testErrors);
      failedTests++;
      errorCount += testErrors;
    end
    testErrors = 0;
  endtask

  // **************************************************
  // Bus drivers
  // **************************************************

  // Setup and access phase; holdMmu raises an MMU read together with penable
  task automatic apbTransfer(input logic write, input logic [3:0] crn, input logic [3:0] crm,
                             input logic [2:0] op2, input logic [31:0] data,
                             input logic holdMmu, input logic [3:0] mmuReg,
                             output logic [31:0] readData, output logic err,
                             output int waits, output logic stallSeen);
    int   cycles;
    logic done;
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = {op2, crm, crn, 2'b00};
    pwdata = data;
    mmuAddr = mmuReg;
    mmuWriteEn = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    mmuEn = holdMmu;
    waits = 0;
    cycles = 0;
    done = 1'b0;
    readData = 32'h0;
    err = 1'b0;
    stallSeen = 1'b0;
    while (!done && cycles < WaitLimit) begin
      @(negedge clk);
      if (pready) begin
        readData = prdata;
        err = pslverr;
        stallSeen = mmuStall;
        done = 1'b1;
      end else begin
        // The MMU wins every wait cycle
        waits++;
        checkValue("mmuStall", {31'h0, mmuStall}, 32'h0);
      end
      cycles++;
    end
    if (!done) begin
      reportFailure("Timeout: pready did not rise within 20 cycles");
    end
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic mmuAccess(input logic write, input logic [3:0] addr, input logic [31:0] data,
                           output logic [31:0] readData);
    int   cycles;
    logic done;
    @(posedge clk);
    #1;
    mmuEn = 1'b1;
    mmuWriteEn = write;
    mmuAddr = addr;
    mmuWriteData = data;
    cycles = 0;
    done = 1'b0;
    readData = 32'h0;
    while (!done && cycles < WaitLimit) begin
      @(negedge clk);
      if (!mmuStall) begin
        readData = mmuReadData;
        done = 1'b1;
      end
      cycles++;
    end
    if (!done) begin
      reportFailure("Timeout: mmuStall stayed high for 20 cycles");
    end
    @(posedge clk);
    #1;
    mmuEn = 1'b0;
    mmuWriteEn = 1'b0;
  endtask

  // **************************************************
  // One vector from the input file
  // **************************************************

  task automatic runVector(input logic [63:0] kind, input logic [3:0] crn,
                           input logic [3:0] crm, input logic [2:0] op2,
                           input logic useRandom, input logic [31:0] wdata,
                           input logic [31:0] expData, input logic expErr,
                           input logic [3:0] expCache, input logic [1:0] expTlb);
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] readData;
    logic        isRead;
    logic        isWrite;
    logic        err;
    logic        stallSeen;
    int          waits;
    data = wdata;
    expected = expData;
    isRead = (kind == KindApbRead) || (kind == KindMmuRead);
    isWrite = (kind == KindApbWrite) || (kind == KindMmuWrite) || (kind == KindConflict);
    if (useRandom && isWrite) begin
      drawRandom(data);
      lastRandom = data;
    end else if (useRandom && isRead) begin
      expected = lastRandom;
    end
    // Control and tbase follow every accepted write
    if (isWrite && !expErr && crn == 4'd1) begin
      controlModel = data;
    end
    if (isWrite && !expErr && crn == 4'd2) begin
      tbaseModel = data;
    end
    if (kind == KindApbRead || kind == KindApbWrite) begin
      apbTransfer(kind == KindApbWrite, crn, crm, op2, data, 1'b0, 4'h0, readData, err,
                  waits, stallSeen);
      if (kind == KindApbRead) begin
        checkValue("prdata", readData, expected);
      end
      // Without an MMU request the transfer has no wait state
      checkValue("wait cycles", waits, 32'h0);
      checkValue("mmuStall", {31'h0, stallSeen}, 32'h0);
      checkValue("pslverr", {31'h0, err}, {31'h0, expErr});
      @(negedge clk);
      checkOutputs(expCache, expTlb);
      @(negedge clk);
      checkOutputs(4'h0, 2'h0);
    end else if (kind == KindMmuRead || kind == KindMmuWrite) begin
      mmuAccess(kind == KindMmuWrite, crn, data, readData);
      if (kind == KindMmuRead) begin
        checkValue("mmuReadData", readData, expected);
      end
      @(negedge clk);
      checkOutputs(4'h0, 2'h0);
    end else if (kind == KindConflict) begin
      apbTransfer(1'b1, crn, 4'h0, op2, data, 1'b1, crm, readData, err, waits, stallSeen);
      checkValue("wait cycles", waits, StallLimit);
      checkValue("mmuStall", {31'h0, stallSeen}, 32'h1);
      checkValue("pslverr", {31'h0, err}, {31'h0, expErr});
      // APB done, the MMU read goes through now
      @(negedge clk);
      checkValue("mmuStall", {31'h0, mmuStall}, 32'h0);
      checkValue("mmuReadData", mmuReadData, expected);
      checkOutputs(expCache, expTlb);
      @(posedge clk);
      #1;
      mmuEn = 1'b0;
      @(negedge clk);
      checkOutputs(4'h0, 2'h0);
    end else begin
      reportFailure("Unknown vector kind in the input file");
    end
  endtask

  initial begin
    int          fd;
    int          lineNo;
    int          fields;
    string       line;
    logic [63:0] kind;
    logic [31:0] crn;
    logic [31:0] crm;
    logic [31:0] op2;
    logic [31:0] useRandom;
    logic [31:0] wdata;
    logic [31:0] expData;
    logic [31:0] expErr;
    logic [31:0] expCache;
    logic [31:0] expTlb;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 13'h0;
    pwdata = 32'h0;
    mmuEn = 1'b0;
    mmuWriteEn = 1'b0;
    mmuAddr = 4'h0;
    mmuWriteData = 32'h0;
    controlModel = 32'h00090078;
    tbaseModel = 32'h0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset state of outputs
    @(negedge clk);
    checkValue("pready", {31'h0, pready}, 32'h0);
    checkValue("pslverr", {31'h0, pslverr}, 32'h0);
    checkValue("mmuStall", {31'h0, mmuStall}, 32'h0);
    checkOutputs(4'h0, 2'h0);
    finishTest(0);

    fd = $fopen("sim/cp15Input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/cp15Input.txt");
      failedTests++;
    end else begin
      lineNo = 0;
      while (!$feof(fd)) begin
        line = "";
        fields = $fgets(line, fd);
        lineNo++;
        if (fields != 0 && line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind, crn, crm, op2,
                           useRandom, wdata, expData, expErr, expCache, expTlb);
          if (fields != 10) begin
            reportFailure("Malformed line in the vector file");
          end else begin
            runVector(kind, crn[3:0], crm[3:0], op2[2:0], useRandom[0], wdata, expData,
                      expErr[0], expCache[3:0], expTlb[1:0]);
          end
          finishTest(lineNo);
        end
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (failedTests == 0 && testCount > 1) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sim/cp15Input.txt
# kind crn crm op2 rnd wdata expData err cache tlb (hex; rnd 1 on a write uses LFSR data)
# rnd 1 on a read expects the last random word; conflict = APB write while MMU reads crm
apbRead  0 0 0 0 00000000 41069265 0 0 0
apbRead  1 0 0 0 00000000 00090078 0 0 0
apbRead  2 0 0 0 00000000 00000000 0 0 0
# Storage readback
apbWrite 1 0 0 0 00091079 00000000 0 0 0
apbRead  1 0 0 0 00000000 00091079 0 0 0
apbWrite 2 0 0 1 00000000 00000000 0 0 0
apbRead  2 0 0 1 00000000 00000000 0 0 0
apbWrite 3 0 0 1 00000000 00000000 0 0 0
apbRead  3 0 0 1 00000000 00000000 0 0 0
apbWrite f 0 0 0 cafef00d 00000000 0 0 0
apbRead  f 0 0 0 00000000 cafef00d 0 0 0
# Error transfers
apbWrite 0 0 0 0 deadbeef 00000000 1 0 0
apbRead  0 0 0 0 00000000 41069265 0 0 0
apbWrite 7 3 0 0 00000000 00000000 1 0 0
apbWrite 7 7 2 0 00000000 00000000 1 0 0
apbWrite 8 4 0 0 00000000 00000000 1 0 0
apbWrite 8 7 4 0 00000000 00000000 1 0 0
# Cache table, mask is flushI flushD cleanI cleanD
apbWrite 7 7 0 0 00000000 00000000 0 c 0
apbWrite 7 7 1 0 00000000 00000000 0 c 0
apbWrite 7 5 0 0 00000000 00000000 0 8 0
apbWrite 7 5 1 0 00000000 00000000 0 8 0
apbWrite 7 6 0 0 00000000 00000000 0 4 0
apbWrite 7 6 1 0 00000000 00000000 0 4 0
apbWrite 7 b 0 0 00000000 00000000 0 3 0
apbWrite 7 b 1 0 00000000 00000000 0 3 0
apbWrite 7 a 0 0 00000000 00000000 0 1 0
apbWrite 7 a 1 0 00000000 00000000 0 1 0
apbWrite 7 f 0 0 00000000 00000000 0 f 0
apbWrite 7 f 1 0 00000000 00000000 0 f 0
apbWrite 7 e 0 0 00000000 00000000 0 5 0
apbWrite 7 e 1 0 00000000 00000000 0 5 0
# TLB table, mask is tlbFlushI tlbFlushD
apbWrite 8 7 0 0 00000000 00000000 0 0 3
apbWrite 8 7 1 0 00000000 00000000 0 0 3
apbWrite 8 5 0 0 00000000 00000000 0 0 2
apbWrite 8 5 1 0 00000000 00000000 0 0 2
apbWrite 8 6 0 0 00000000 00000000 0 0 1
apbWrite 8 6 1 0 00000000 00000000 0 0 1
# MMU port against APB
mmuWrite 4 0 0 0 a5a5a5a5 00000000 0 0 0
apbRead  4 0 0 0 00000000 a5a5a5a5 0 0 0
apbWrite 5 0 0 0 0badf00d 00000000 0 0 0
mmuRead  5 0 0 0 00000000 0badf00d 0 0 0
mmuWrite 2 0 0 1 00000000 00000000 0 0 0
apbRead  2 0 0 1 00000000 00000000 0 0 0
mmuRead  0 0 0 0 00000000 41069265 0 0 0
mmuWrite 1 0 0 0 00090078 00000000 0 0 0
apbRead  1 0 0 0 00000000 00090078 0 0 0
# Conflicts with the MMU reading register crm
conflict 6 4 0 0 13579bdf a5a5a5a5 0 0 0
apbRead  6 0 0 0 00000000 13579bdf 0 0 0
conflict 2 5 0 1 00000000 0badf00d 0 0 0
apbRead  2 0 0 1 00000000 00000000 0 0 0
conflict 0 6 0 0 ffffffff 13579bdf 1 0 0
apbRead  0 0 0 0 00000000 41069265 0 0 0

// File: tb.f
hdl/cp15Pkg.sv
hdl/cp15Decode.sv
hdl/cp15RegFile.sv
hdl/cp15Execute.sv
hdl/cp15Result.sv
hdl/cp15Top.sv
sim/cp15Tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CP15 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cp15Tb -f tb.f -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
exit 0
